/* hdl/mcs_defs.svh */
/*
 * Shared constants for the MCS-51 style core.
 * Only the opcodes of the kept instruction subset are listed, and every
 * other opcode runs as a one-byte NOP. Phase codes follow the S1..S8
 * machine cycle, one clock per phase.
 */
`ifndef MCS_DEFS_SVH
`define MCS_DEFS_SVH

// Widths and sizes
`define MCS_DATA_W        8
`define MCS_ADDR_W        16
`define MCS_PHASE_W       4
`define MCS_ALU_OP_W      4
`define MCS_SRC_W         2
`define MCS_IRAM_DEPTH    128
`define MCS_IRAM_AW       7

// Opcodes of the kept subset
`define MCS_OP_NOP        8'h00
`define MCS_OP_MOV_A_IMM  8'h74
`define MCS_OP_MOV_A_DIR  8'hE5
`define MCS_OP_MOV_DIR_A  8'hF5
`define MCS_OP_ADD_IMM    8'h24
`define MCS_OP_ADDC_IMM   8'h34
`define MCS_OP_ANL_IMM    8'h54
`define MCS_OP_ORL_IMM    8'h44
`define MCS_OP_XRL_IMM    8'h64
`define MCS_OP_CLR_A      8'hE4
`define MCS_OP_CPL_A      8'hF4
`define MCS_OP_RL_A       8'h23
`define MCS_OP_RR_A       8'h03
`define MCS_OP_SWAP_A     8'hC4
`define MCS_OP_SJMP       8'h80

// Register-form prefixes, low three bits pick Rn
`define MCS_PFX_MOV_A_RN  5'b11101
`define MCS_PFX_MOV_RN_A  5'b11111

// Machine-cycle phases
`define MCS_S1_0          4'd0
`define MCS_S1_1          4'd1
`define MCS_S2_0          4'd2
`define MCS_S2_1          4'd3
`define MCS_S3_0          4'd4
`define MCS_S3_1          4'd5
`define MCS_S4_0          4'd6
`define MCS_S4_1          4'd7
`define MCS_S5_0          4'd8
`define MCS_S5_1          4'd9
`define MCS_S6_0          4'd10
`define MCS_S6_1          4'd11
`define MCS_S7_0          4'd12
`define MCS_S7_1          4'd13
`define MCS_S8_0          4'd14
`define MCS_S8_1          4'd15

// ALU operations
`define MCS_ALU_SUM       4'h0
`define MCS_ALU_ANDS      4'h1
`define MCS_ALU_XOR       4'h2
`define MCS_ALU_OR        4'h3
`define MCS_ALU_RL        4'h4
`define MCS_ALU_CPL       4'h5
`define MCS_ALU_RR        4'h8
`define MCS_ALU_SWAP      4'h9

// Accumulator write source
`define MCS_SRC_ALU       2'd0
`define MCS_SRC_OPND      2'd1
`define MCS_SRC_ZERO      2'd2

// SFR addresses and reset values
`define MCS_SFR_ACC       8'hE0
`define MCS_SFR_PSW       8'hD0
`define MCS_SFR_P1        8'h90
`define MCS_P1_RESET      8'hFF

`endif

/* hdl/mcs_isa_pkg.sv */
/*
 * Instruction byte type. The same byte reads either as a full opcode
 * or as a register-form prefix plus an Rn index.
 */
package mcs_isa_pkg;

	// Register-form view, prefix in the top five bits
	typedef struct packed {
		logic [4:0] prefix;
		logic [2:0] rn;
	} reg_form_t;

	typedef union packed {
		logic [7:0] opcode;
		reg_form_t  reg_form;
	} instr_u;

endpackage

/* hdl/mcs_phase_seq.sv */
/*
 * Machine-cycle phase sequencer. Waits on ready_i in S1_0 and S2_0,
 * skips S2 for one-byte instructions. psen_n_o is registered, so it
 * stays high for the first cycle after reset.
 */
`timescale 1ns/1ps
`include "mcs_defs.svh"

module mcs_phase_seq (
	input  logic                    clk,
	input  logic                    sys_rst_n,
	input  logic                    ready_i,
	input  logic                    need_operand_i,
	input  logic                    mem_write_i,
	output logic [`MCS_PHASE_W-1:0] phase_o,
	output logic                    psen_n_o
);

	logic [`MCS_PHASE_W-1:0] phase_q;
	logic [`MCS_PHASE_W-1:0] phase_d;
	logic                    fetch_d;

	always_comb
	begin
		phase_d = phase_q;
		case (phase_q)
			`MCS_S1_0: if (ready_i) phase_d = `MCS_S1_1;
			`MCS_S1_1: phase_d = need_operand_i ? `MCS_S2_0 : `MCS_S4_0;
			`MCS_S2_0: if (ready_i) phase_d = `MCS_S2_1;
			`MCS_S2_1: phase_d = `MCS_S4_0;
			// S3 is never entered, recover straight into execute
			`MCS_S3_0, `MCS_S3_1: phase_d = `MCS_S4_0;
			`MCS_S4_0: phase_d = `MCS_S4_1;
			`MCS_S4_1: phase_d = `MCS_S5_0;
			`MCS_S5_0: phase_d = `MCS_S5_1;
			`MCS_S5_1: phase_d = `MCS_S6_0;
			`MCS_S6_0: phase_d = `MCS_S6_1;
			`MCS_S6_1: phase_d = `MCS_S7_0;
			`MCS_S7_0: phase_d = `MCS_S7_1;
			`MCS_S7_1: phase_d = `MCS_S8_0;
			`MCS_S8_0: phase_d = `MCS_S8_1;
			default:   phase_d = `MCS_S1_0;
		endcase
	end

	// Program store is enabled across both fetch cycles
	assign fetch_d = phase_d inside {`MCS_S1_0, `MCS_S1_1, `MCS_S2_0, `MCS_S2_1};

	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			phase_q  <= `MCS_S1_0;
			psen_n_o <= 1'b1;
		end
		else
		begin
			phase_q  <= phase_d;
			psen_n_o <= !fetch_d;
		end
	end

	assign phase_o = phase_q;

	// ------------------------------------------------------------------------
	a_psen_in_fetch: assert property (@(posedge clk) disable iff (!sys_rst_n)
		!psen_n_o |-> phase_q inside {`MCS_S1_0, `MCS_S1_1, `MCS_S2_0, `MCS_S2_1});

	a_hold_on_wait: assert property (@(posedge clk) disable iff (!sys_rst_n)
		(phase_q inside {`MCS_S1_0, `MCS_S2_0} && !ready_i) |=> $stable(phase_q));

	// Decoder must only strobe the direct write in its own slot
	a_write_slot: assert property (@(posedge clk) disable iff (!sys_rst_n)
		mem_write_i |-> phase_q == `MCS_S6_1);

endmodule

/* hdl/mcs_decoder.sv */
/*
 * Instruction decoder. Classifies the opcode and drives the per-phase
 * controls: writeback strobes only in S4_1, the direct write in S6_1
 * and the jump in S7_0. Unknown opcodes decode as NOP.
 */
`timescale 1ns/1ps
`include "mcs_defs.svh"

module mcs_decoder import mcs_isa_pkg::*; (
	input  instr_u                   instr_i,
	input  logic [`MCS_PHASE_W-1:0]  phase_i,
	output logic                     need_operand_o,
	output logic                     mem_write_o,
	output logic [`MCS_ALU_OP_W-1:0] alu_op_o,
	output logic [`MCS_SRC_W-1:0]    alu_src_o,
	output logic                     use_carry_o,
	output logic                     acc_write_o,
	output logic                     flag_write_o,
	output logic                     rn_write_o,
	output logic                     dir_read_o,
	output logic                     jump_o
);

	// Raw controls before phase gating
	logic acc_wr;
	logic flag_wr;
	logic rn_wr;
	logic mem_wr;
	logic jmp;

	always_comb
	begin
		need_operand_o = 1'b0;
		alu_op_o       = `MCS_ALU_SUM;
		alu_src_o      = `MCS_SRC_ALU;
		use_carry_o    = 1'b0;
		dir_read_o     = 1'b0;
		acc_wr         = 1'b0;
		flag_wr        = 1'b0;
		rn_wr          = 1'b0;
		mem_wr         = 1'b0;
		jmp            = 1'b0;
		if (instr_i.reg_form.prefix == `MCS_PFX_MOV_A_RN)
		begin
			alu_src_o = `MCS_SRC_OPND;
			acc_wr    = 1'b1;
		end
		else if (instr_i.reg_form.prefix == `MCS_PFX_MOV_RN_A)
			rn_wr = 1'b1;
		else
		begin
			case (instr_i.opcode)
				`MCS_OP_MOV_A_IMM:
				begin
					need_operand_o = 1'b1;
					alu_src_o      = `MCS_SRC_OPND;
					acc_wr         = 1'b1;
				end
				`MCS_OP_MOV_A_DIR:
				begin
					need_operand_o = 1'b1;
					dir_read_o     = 1'b1;
					alu_src_o      = `MCS_SRC_OPND;
					acc_wr         = 1'b1;
				end
				`MCS_OP_MOV_DIR_A:
				begin
					need_operand_o = 1'b1;
					mem_wr         = 1'b1;
				end
				`MCS_OP_ADD_IMM, `MCS_OP_ADDC_IMM:
				begin
					need_operand_o = 1'b1;
					use_carry_o    = instr_i.opcode == `MCS_OP_ADDC_IMM;
					acc_wr         = 1'b1;
					flag_wr        = 1'b1;
				end
				`MCS_OP_ANL_IMM, `MCS_OP_ORL_IMM, `MCS_OP_XRL_IMM:
				begin
					need_operand_o = 1'b1;
					acc_wr         = 1'b1;
					// Logic ops leave the flags alone
					if (instr_i.opcode == `MCS_OP_ANL_IMM)
						alu_op_o = `MCS_ALU_ANDS;
					else if (instr_i.opcode == `MCS_OP_ORL_IMM)
						alu_op_o = `MCS_ALU_OR;
					else
						alu_op_o = `MCS_ALU_XOR;
				end
				`MCS_OP_CLR_A:
				begin
					alu_src_o = `MCS_SRC_ZERO;
					acc_wr    = 1'b1;
				end
				`MCS_OP_CPL_A:
				begin
					alu_op_o = `MCS_ALU_CPL;
					acc_wr   = 1'b1;
				end
				`MCS_OP_RL_A:
				begin
					alu_op_o = `MCS_ALU_RL;
					acc_wr   = 1'b1;
				end
				`MCS_OP_RR_A:
				begin
					alu_op_o = `MCS_ALU_RR;
					acc_wr   = 1'b1;
				end
				`MCS_OP_SWAP_A:
				begin
					alu_op_o = `MCS_ALU_SWAP;
					acc_wr   = 1'b1;
				end
				`MCS_OP_SJMP:
				begin
					need_operand_o = 1'b1;
					jmp            = 1'b1;
				end
				`MCS_OP_NOP:
				begin
					// Default control set already applies
				end
				default:
				begin
					// Unsupported opcode, run as NOP
				end
			endcase
		end
	end

	assign acc_write_o  = acc_wr && (phase_i == `MCS_S4_1);
	assign flag_write_o = flag_wr && (phase_i == `MCS_S4_1);
	assign rn_write_o   = rn_wr && (phase_i == `MCS_S4_1);
	assign mem_write_o  = mem_wr && (phase_i == `MCS_S6_1);
	assign jump_o       = jmp && (phase_i == `MCS_S7_0);

endmodule

/* hdl/mcs_alu.sv */
/*
 * Eight-operation ALU. Flags are only meaningful for the sum and read
 * as zero for every other operation. RL and RR rotate without carry.
 */
`timescale 1ns/1ps
`include "mcs_defs.svh"

module mcs_alu (
	input  logic [`MCS_ALU_OP_W-1:0] op_i,
	input  logic [`MCS_DATA_W-1:0]   a_i,
	input  logic [`MCS_DATA_W-1:0]   b_i,
	input  logic                     cy_i,
	output logic [`MCS_DATA_W-1:0]   result_o,
	output logic                     cy_o,
	output logic                     ac_o,
	output logic                     ov_o
);

	logic [3:0] sum_lo;
	logic [2:0] sum_mid;
	logic       sum_hi;
	logic       c3;
	logic       c6;
	logic       c7;

	// Add split at bit 3 and bit 6 for the auxiliary carry and overflow
	always_comb
	begin
		{c3, sum_lo}  = a_i[3:0] + b_i[3:0] + cy_i;
		{c6, sum_mid} = a_i[6:4] + b_i[6:4] + c3;
		{c7, sum_hi}  = a_i[7] + b_i[7] + c6;
	end

	always_comb
	begin
		case (op_i)
			`MCS_ALU_SUM:  result_o = {sum_hi, sum_mid, sum_lo};
			`MCS_ALU_ANDS: result_o = a_i & b_i;
			`MCS_ALU_XOR:  result_o = a_i ^ b_i;
			`MCS_ALU_OR:   result_o = a_i | b_i;
			`MCS_ALU_RL:   result_o = {a_i[6:0], a_i[7]};
			`MCS_ALU_RR:   result_o = {a_i[0], a_i[7:1]};
			`MCS_ALU_CPL:  result_o = ~a_i;
			`MCS_ALU_SWAP: result_o = {a_i[3:0], a_i[7:4]};
			default:       result_o = '0;
		endcase
	end

	assign cy_o = (op_i == `MCS_ALU_SUM) && c7;
	assign ac_o = (op_i == `MCS_ALU_SUM) && c3;
	// Signed overflow is carry out of bit 7 against carry into it
	assign ov_o = (op_i == `MCS_ALU_SUM) && (c7 ^ c6);

endmodule

/* hdl/mcs_datapath.sv */
/*
 * Datapath: PC, fetch buffers, A, PSW, 128-byte internal RAM and P1.
 * Direct reads above 7Fh return ACC, PSW or P1, zero for other SFRs.
 * A write to ACC through a direct address stores A into itself.
 * The opcode is bypassed from mem_rdata_i during S1_1.
 */
`timescale 1ns/1ps
`include "mcs_defs.svh"

module mcs_datapath import mcs_isa_pkg::*; (
	input  logic                    clk,
	input  logic                    sys_rst_n,
	input  logic [`MCS_PHASE_W-1:0] phase_i,
	input  logic                    need_operand_i,
	input  logic                    mem_write_i,
	input  logic [`MCS_SRC_W-1:0]   alu_src_i,
	input  logic                    use_carry_i,
	input  logic                    acc_write_i,
	input  logic                    flag_write_i,
	input  logic                    rn_write_i,
	input  logic                    dir_read_i,
	input  logic                    jump_i,
	input  logic [`MCS_DATA_W-1:0]  alu_result_i,
	input  logic                    alu_cy_i,
	input  logic                    alu_ac_i,
	input  logic                    alu_ov_i,
	input  logic [`MCS_DATA_W-1:0]  mem_rdata_i,
	output instr_u                  instr_o,
	output logic [`MCS_DATA_W-1:0]  acc_o,
	output logic [`MCS_DATA_W-1:0]  operand_o,
	output logic                    carry_o,
	output logic [`MCS_ADDR_W-1:0]  mem_addr_o,
	output logic [`MCS_DATA_W-1:0]  p1_o
);

	logic [`MCS_ADDR_W-1:0] pc_q;
	instr_u                 opcode_q;
	logic [`MCS_DATA_W-1:0] operand_q;
	logic [`MCS_DATA_W-1:0] acc_q;
	logic [`MCS_DATA_W-1:0] acc_d;
	// PSW bits 7..1, parity is rebuilt from A
	logic [7:1]             psw_q;
	logic [`MCS_DATA_W-1:0] psw_rd;
	logic [`MCS_DATA_W-1:0] p1_q;
	logic [`MCS_DATA_W-1:0] iram [`MCS_IRAM_DEPTH];
	logic [`MCS_DATA_W-1:0] rn_addr;
	logic [`MCS_DATA_W-1:0] rd_addr;
	logic [`MCS_DATA_W-1:0] rd_data;
	logic [`MCS_DATA_W-1:0] wr_addr;
	logic                   ram_we;
	logic                   sfr_we;

	// ------------------------------------------------------------------------
	// Fetch side
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			pc_q     <= '0;
			opcode_q <= `MCS_OP_NOP;
		end
		else if (phase_i == `MCS_S1_1)
		begin
			opcode_q <= mem_rdata_i;
			pc_q     <= pc_q + 1'b1;
		end
		else if (phase_i == `MCS_S2_1)
			pc_q <= pc_q + 1'b1;
		else if (jump_i)
			pc_q <= pc_q + {{(`MCS_ADDR_W - `MCS_DATA_W){operand_q[7]}}, operand_q};
	end

	always_ff @(posedge clk)
	begin
		if (phase_i == `MCS_S2_1)
			operand_q <= mem_rdata_i;
	end

	always_comb
	begin
		instr_o = opcode_q;
		if (phase_i == `MCS_S1_1)
			instr_o.opcode = mem_rdata_i;
	end

	// ------------------------------------------------------------------------
	// Register file reads, bank select from RS1:RS0
	// ------------------------------------------------------------------------
	assign rn_addr = {3'b000, psw_q[4:3], opcode_q.reg_form.rn};
	assign rd_addr = dir_read_i ? operand_q : rn_addr;
	assign psw_rd  = {psw_q, ^acc_q};

	always_comb
	begin
		rd_data = '0;
		if (!rd_addr[7])
			rd_data = iram[rd_addr[`MCS_IRAM_AW-1:0]];
		else
		begin
			case (rd_addr)
				`MCS_SFR_ACC: rd_data = acc_q;
				`MCS_SFR_PSW: rd_data = psw_rd;
				`MCS_SFR_P1:  rd_data = p1_q;
				default:      rd_data = '0;
			endcase
		end
	end

	// Immediate byte unless the source is a register or direct address
	assign operand_o = (dir_read_i || !need_operand_i) ? rd_data : operand_q;

	always_comb
	begin
		case (alu_src_i)
			`MCS_SRC_ALU:  acc_d = alu_result_i;
			`MCS_SRC_OPND: acc_d = operand_o;
			`MCS_SRC_ZERO: acc_d = '0;
			default:       acc_d = '0;
		endcase
	end

	// ------------------------------------------------------------------------
	// Writeback
	// ------------------------------------------------------------------------
	assign wr_addr = rn_write_i ? rn_addr : operand_q;
	assign ram_we  = rn_write_i || (mem_write_i && !operand_q[7]);
	assign sfr_we  = mem_write_i && operand_q[7];

	always_ff @(posedge clk)
	begin
		if (ram_we)
			iram[wr_addr[`MCS_IRAM_AW-1:0]] <= acc_q;
	end

	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			acc_q <= '0;
			psw_q <= '0;
			p1_q  <= `MCS_P1_RESET;
		end
		else
		begin
			if (acc_write_i)
				acc_q <= acc_d;
			if (flag_write_i)
				{psw_q[7], psw_q[6], psw_q[2]} <= {alu_cy_i, alu_ac_i, alu_ov_i};
			else if (sfr_we && operand_q == `MCS_SFR_PSW)
				psw_q <= acc_q[7:1];
			if (sfr_we && operand_q == `MCS_SFR_P1)
				p1_q <= acc_q;
		end
	end

	assign acc_o      = acc_q;
	assign carry_o    = use_carry_i && psw_q[7];
	assign mem_addr_o = pc_q;
	assign p1_o       = p1_q;

	a_ram_index: assert property (@(posedge clk) disable iff (!sys_rst_n)
		ram_we |-> wr_addr < `MCS_IRAM_DEPTH);

endmodule

/* hdl/mcs_core.sv */
/*
 * Core top level. Program memory answers mem_addr_o while psen_n_o is
 * low; ready_i low in a fetch phase stalls the whole core.
 */
`timescale 1ns/1ps
`include "mcs_defs.svh"

module mcs_core import mcs_isa_pkg::*; (
	input  logic                   clk,
	input  logic                   sys_rst_n,
	input  logic [`MCS_DATA_W-1:0] mem_rdata_i,
	input  logic                   ready_i,
	output logic [`MCS_ADDR_W-1:0] mem_addr_o,
	output logic                   psen_n_o,
	output logic [`MCS_DATA_W-1:0] p1_o
);

	logic [`MCS_PHASE_W-1:0]  phase;
	logic                     need_operand;
	logic                     mem_write;
	logic [`MCS_ALU_OP_W-1:0] alu_op;
	logic [`MCS_SRC_W-1:0]    alu_src;
	logic                     use_carry;
	logic                     acc_write;
	logic                     flag_write;
	logic                     rn_write;
	logic                     dir_read;
	logic                     jump;
	instr_u                   instr;
	logic [`MCS_DATA_W-1:0]   acc;
	logic [`MCS_DATA_W-1:0]   operand;
	logic                     carry;
	logic [`MCS_DATA_W-1:0]   alu_result;
	logic                     alu_cy;
	logic                     alu_ac;
	logic                     alu_ov;

	mcs_phase_seq u_seq (
		.clk            (clk),
		.sys_rst_n      (sys_rst_n),
		.ready_i        (ready_i),
		.need_operand_i (need_operand),
		.mem_write_i    (mem_write),
		.phase_o        (phase),
		.psen_n_o       (psen_n_o)
	);

	mcs_decoder u_dec (
		.instr_i        (instr),
		.phase_i        (phase),
		.need_operand_o (need_operand),
		.mem_write_o    (mem_write),
		.alu_op_o       (alu_op),
		.alu_src_o      (alu_src),
		.use_carry_o    (use_carry),
		.acc_write_o    (acc_write),
		.flag_write_o   (flag_write),
		.rn_write_o     (rn_write),
		.dir_read_o     (dir_read),
		.jump_o         (jump)
	);

	mcs_alu u_alu (
		.op_i     (alu_op),
		.a_i      (acc),
		.b_i      (operand),
		.cy_i     (carry),
		.result_o (alu_result),
		.cy_o     (alu_cy),
		.ac_o     (alu_ac),
		.ov_o     (alu_ov)
	);

	mcs_datapath u_dp (
		.clk            (clk),
		.sys_rst_n      (sys_rst_n),
		.phase_i        (phase),
		.need_operand_i (need_operand),
		.mem_write_i    (mem_write),
		.alu_src_i      (alu_src),
		.use_carry_i    (use_carry),
		.acc_write_i    (acc_write),
		.flag_write_i   (flag_write),
		.rn_write_i     (rn_write),
		.dir_read_i     (dir_read),
		.jump_i         (jump),
		.alu_result_i   (alu_result),
		.alu_cy_i       (alu_cy),
		.alu_ac_i       (alu_ac),
		.alu_ov_i       (alu_ov),
		.mem_rdata_i    (mem_rdata_i),
		.instr_o        (instr),
		.acc_o          (acc),
		.operand_o      (operand),
		.carry_o        (carry),
		.mem_addr_o     (mem_addr_o),
		.p1_o           (p1_o)
	);

endmodule

/* verif/tb_mcs_core.sv */
/*
 * Testbench for mcs_core. Program image and expected results come from
 * verif/mcs_golden.txt, which is read relative to the project root.
 * ready_i drops at random, and P1 writes are seen as changes on p1_o,
 * so consecutive expected P1 values must differ.
 */
`timescale 1ns/1ps
`include "mcs_defs.svh"

module tb_mcs_core;

	localparam int GOLDEN_WORDS = 256;
	localparam int NUM_TESTS    = 5;
	localparam int RUN_LIMIT    = 5000;
	localparam int IDLE_LIMIT   = 400;

	logic                   clk;
	logic                   sys_rst_n;
	logic [`MCS_DATA_W-1:0] mem_rdata;
	logic                   ready;
	logic [`MCS_ADDR_W-1:0] mem_addr;
	logic                   psen_n;
	logic [`MCS_DATA_W-1:0] p1;

	// Golden word is {kind, address or test, data}
	logic [27:0]            golden [0:GOLDEN_WORDS-1];
	logic [`MCS_DATA_W-1:0] prog [0:(1 << `MCS_ADDR_W)-1];
	logic [`MCS_DATA_W-1:0] exp_p1 [$];
	int                     p1_test [$];
	logic [`MCS_ADDR_W-1:0] exp_jump [$];
	int                     jump_test [$];
	int                     remaining [0:NUM_TESTS];
	int                     test_errors [0:NUM_TESTS];
	integer                 seed;
	int                     checks;
	int                     errors;
	int                     tests_passed;

	mcs_core UUT (
		.clk         (clk),
		.sys_rst_n   (sys_rst_n),
		.mem_rdata_i (mem_rdata),
		.ready_i     (ready),
		.mem_addr_o  (mem_addr),
		.psen_n_o    (psen_n),
		.p1_o        (p1)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Compare tasks and bookkeeping
	// ------------------------------------------------------------------------
	task automatic check_port(input string name, input int test,
		input logic [`MCS_DATA_W-1:0] got, input logic [`MCS_DATA_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED at %0d ns: %s = %02h, expected %02h", $time, name, got, exp);
			errors++;
			test_errors[test]++;
		end
	endtask

	task automatic check_addr(input string name, input int test,
		input logic [`MCS_ADDR_W-1:0] got, input logic [`MCS_ADDR_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED at %0d ns: %s = %04h, expected %04h", $time, name, got, exp);
			errors++;
			test_errors[test]++;
		end
	endtask

	// One line per test once its last expected event is seen
	task automatic close_event(input int test);
		remaining[test]--;
		if (remaining[test] == 0)
		begin
			if (test_errors[test] == 0)
			begin
				tests_passed++;
				$display("Test %0d passed", test);
			end
			else
				$display("Test %0d failed with %0d errors", test, test_errors[test]);
		end
	endtask

	task automatic load_golden();
		int          i;
		logic [3:0]  kind;
		logic [15:0] field;
		logic [7:0]  data;
		// Unused program bytes get an address-dependent pattern
		for (i = 0; i < (1 << `MCS_ADDR_W); i++)
			prog[i] = 8'(i ^ (i >> 8));
		for (i = 0; i < GOLDEN_WORDS; i++)
			golden[i] = '0;
		$readmemh("verif/mcs_golden.txt", golden);
		for (i = 0; i < GOLDEN_WORDS; i++)
		begin
			kind  = golden[i][27:24];
			field = golden[i][23:8];
			data  = golden[i][7:0];
			case (kind)
				4'd1: prog[field] = data;
				4'd2:
				begin
					exp_p1.push_back(data);
					p1_test.push_back(int'(field));
					remaining[field]++;
				end
				4'd3:
				begin
					exp_jump.push_back(field);
					jump_test.push_back(int'(data));
					remaining[data]++;
				end
				default:
				begin
				end
			endcase
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		int                     cycles;
		int                     idle;
		int                     p1_idx;
		int                     jump_idx;
		int                     t;
		logic                   timed_out;
		logic                   prev_psen;
		logic [`MCS_DATA_W-1:0] prev_p1;
		logic [`MCS_ADDR_W-1:0] last_fetch;

		seed       = 34038;
		sys_rst_n  = 1'b0;
		ready      = 1'b1;
		mem_rdata  = '0;
		checks     = 0;
		errors     = 0;
		tests_passed = 0;
		for (t = 0; t <= NUM_TESTS; t++)
		begin
			remaining[t]   = 0;
			test_errors[t] = 0;
		end
		load_golden();
		if (exp_p1.size() == 0 || exp_jump.size() == 0)
		begin
			$display("Golden file gave no expected P1 writes or jump targets");
			errors++;
		end

		repeat (3)
			@(negedge clk);

		// Reset values count toward test 1
		check_port("p1_o", 1, p1, `MCS_P1_RESET);
		check_addr("mem_addr_o", 1, mem_addr, '0);
		if (psen_n !== 1'b1)
		begin
			$display("Program store enable is active during reset");
			errors++;
			test_errors[1]++;
		end

		sys_rst_n  = 1'b1;
		prev_psen  = psen_n;
		prev_p1    = p1;
		last_fetch = '0;
		cycles     = 0;
		idle       = 0;
		p1_idx     = 0;
		jump_idx   = 0;
		timed_out  = 1'b0;

		while (!timed_out && (p1_idx < exp_p1.size() || jump_idx < exp_jump.size()))
		begin
			@(negedge clk);
			cycles++;
			idle++;

			if (p1 !== prev_p1)
			begin
				idle = 0;
				if (p1_idx < exp_p1.size())
				begin
					check_port("p1_o", p1_test[p1_idx], p1, exp_p1[p1_idx]);
					close_event(p1_test[p1_idx]);
					p1_idx++;
				end
				else
				begin
					$display("P1 changed to %02h after the last expected write", p1);
					errors++;
				end
				prev_p1 = p1;
			end

			// Opcode fetch start is checked when an SJMP came before
			if (prev_psen && !psen_n)
			begin
				if (prog[last_fetch] == `MCS_OP_SJMP && jump_idx < exp_jump.size())
				begin
					idle = 0;
					check_addr("mem_addr_o", jump_test[jump_idx], mem_addr, exp_jump[jump_idx]);
					close_event(jump_test[jump_idx]);
					jump_idx++;
				end
				last_fetch = mem_addr;
			end
			prev_psen = psen_n;

			// Inputs for the next rising edge
			ready = (($random(seed) & 3) != 0);
			if (!psen_n)
				mem_rdata = prog[mem_addr];

			if (idle >= IDLE_LIMIT)
			begin
				$display("Timeout: no P1 write or jump seen for %0d cycles", IDLE_LIMIT);
				timed_out = 1'b1;
			end
			else if (cycles >= RUN_LIMIT)
			begin
				$display("Timeout: program did not finish within %0d cycles", RUN_LIMIT);
				timed_out = 1'b1;
			end
		end

		if (timed_out)
			errors++;
		for (t = 1; t <= NUM_TESTS; t++)
		begin
			if (remaining[t] > 0)
				$display("Test %0d did not finish, %0d events missing", t, remaining[t]);
		end
		$display("Done: %0d of %0d tests passed, %0d checks, %0d errors",
			tests_passed, NUM_TESTS, checks, errors);
		if (errors == 0 && tests_passed == NUM_TESTS)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* verif/mcs_golden.txt */
// Word KAAAADD in hex: K kind, AAAA address or test number, DD data byte
// K=1 program byte DD at AAAA, K=2 P1 write DD in test AAAA, K=3 fetch at AAAA after SJMP (test DD)
// Test 1, immediate load to P1
1000074 100015A 10002F5 1000390
// Test 2, ADD and ADDC flags read back through PSW
1000474 1000578 1000624 1000788
10008E5 10009D0 1000AF5 1000B90
1000C74 1000D45 1000E34 1000F3A
10010E5 10011D0 10012F5 1001390
// Test 3, logic, rotate, swap, clear, NOP and unsupported opcode
1001474 10015F0 1001654 100173C
10018F5 1001990 1001A44 1001B0F
1001CF5 1001D90 1001E64 1001FFF
10020F5 1002190 10022F4 10023F5 1002490
1002523 10026F5 1002790 1002803
10029F5 1002A90 1002BC4 1002CF5 1002D90
1002EE4 1002FF5 1003090 1003100 10032A5
10033F4 10034F5 1003590
// Test 4, register banks and direct RAM
1003674 1003711 10038F8
1003974 1003A10 1003BF5 1003CD0
1003D74 1003E22 1003FF8
1004074 1004100 10042E8 10043F5 1004490
1004574 1004600 10047F5 10048D0
10049E8 1004AF5 1004B90
1004CE5 1004D10 1004EF5 1004F90
1005074 100516B 10052F5 1005340
1005474 1005500 10056E5 1005740
10058F5 1005990 1005AE5 1005BA0
1005CF5 1005D90
// Test 5, SJMP forward and backward, bytes at 60h are jumped over
1005E80 1005F04
1006074 10061EE 10062F5 1006390
1006474 10065A7 10066F5 1006790
1006880 1006908
1006A74 1006B3C 1006CF5 1006D90
1006E80 1006F06
1007280 10073F6
1007680 10077FE
// Expected P1 writes in order
200015A
20002C0 2000245
2000330 200033F 20003C0 200033F 200037E 200033F 20003F3 2000300 20003FF
2000422 2000411 2000422 200046B 2000400
20005A7 200053C
// Expected fetch addresses after each SJMP, the last is the self-loop
3006405 3007205 3006A05 3007605 3007605

/* tb.f */
+incdir+hdl
hdl/mcs_isa_pkg.sv
hdl/mcs_phase_seq.sv
hdl/mcs_decoder.sv
hdl/mcs_alu.sv
hdl/mcs_datapath.sv
hdl/mcs_core.sv
verif/tb_mcs_core.sv

/* run_verilator.sh */
#!/bin/sh
# Builds and runs the mcs_core testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_mcs_core -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_mcs_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
exit 0
